// File: all.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/instr_decoder.sv
hdl/target_address_generator.sv
hdl/execute_stage.sv
hdl/register_file.sv
hdl/fetch_sequencer.sv
hdl/branch_core_top.sv
testbench/tb_branch_core.sv

// File: hdl/branch_core_top.sv
/* top of the control-flow core; wishbone classic read only, no we or sel */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module branch_core_top import rv_core_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   arst_n_i,
	output wb_req_t                     wb_req_o,
	input  wire logic                   wb_ack_i,
	input  wire logic [`RV_XLEN-1:0]    wb_dat_i,
	output logic                        retire_valid_o,
	output retire_t                     retire_o,
	output logic                        halted_o
);

	logic [31:0]            instr;
	logic [`RV_XLEN-1:0]    pc;
	decoded_t               dec;
	logic [`RV_XLEN-1:0]    src1;
	logic [`RV_XLEN-1:0]    src2;
	retire_t                retire;
	logic                   illegal;
	logic                   rf_we;
	logic [4:0]             rf_waddr;
	logic [`RV_XLEN-1:0]    rf_wdata;

	instr_decoder u_instr_decoder (
		.instr_i (instr),
		.dec_o   (dec)
	);

	execute_stage u_execute_stage (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.dec_i     (dec),
		.pc_i      (pc),
		.src1_i    (src1),
		.src2_i    (src2),
		.retire_o  (retire),
		.illegal_o (illegal)
	);

	register_file u_register_file (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.raddr1_i (dec.rs1),
		.raddr2_i (dec.rs2),
		.rdata1_o (src1),
		.rdata2_o (src2),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	fetch_sequencer u_fetch_sequencer (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.wb_req_o       (wb_req_o),
		.wb_ack_i       (wb_ack_i),
		.wb_dat_i       (wb_dat_i),
		.instr_o        (instr),
		.pc_o           (pc),
		.retire_i       (retire),
		.illegal_i      (illegal),
		.rf_we_o        (rf_we),
		.rf_waddr_o     (rf_waddr),
		.rf_wdata_o     (rf_wdata),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.halted_o       (halted_o)
	);

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
/* single-cycle execute; any exception forces pc+4 and drops the register write
   retire record is only meaningful when illegal_o is low */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module execute_stage import rv_core_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   arst_n_i,
	input  decoded_t                    dec_i,
	input  wire logic [`RV_XLEN-1:0]    pc_i,
	input  wire logic [`RV_XLEN-1:0]    src1_i,
	input  wire logic [`RV_XLEN-1:0]    src2_i,
	output retire_t                     retire_o,
	output logic                        illegal_o  // unknown opcode, sequencer halts
);

	logic                   flag_jump;
	logic [`RV_XLEN-1:0]    addr_target;
	logic [`RV_XLEN-1:0]    addr_link;
	exc_e                   exc;
	logic [`RV_XLEN-1:0]    wdata;
	logic                   we;

	target_address_generator u_target_address_generator (
		.clk_i            (clk_i),
		.arst_n_i         (arst_n_i),
		.dec_i            (dec_i),
		.pc_i             (pc_i),
		.src1_i           (src1_i),
		.src2_i           (src2_i),
		.flag_jump_o      (flag_jump),
		.addr_target_o    (addr_target),
		.addr_writeback_o (addr_link),
		.exc_o            (exc)
	);

	// writeback value by class
	always_comb begin
		wdata = '0;
		we    = 1'b0;
		case (dec_i.encoding)
			ENC_JAL,
			ENC_JALR: begin
				wdata = addr_link;  // pc+4
				we    = 1'b1;
			end
			ENC_ADDI: begin
				wdata = src1_i + dec_i.imm;
				we    = 1'b1;
			end
			ENC_LUI: begin
				wdata = dec_i.imm;  // already shifted by decoder
				we    = 1'b1;
			end
			default: ;  // branches and illegal words write nothing
		endcase
	end

	// retire record
	// ------------------------------
	assign retire_o.pc      = pc_i;
	assign retire_o.next_pc = (flag_jump && exc == EXC_NONE) ? addr_target : pc_i + 32'd4;
	assign retire_o.rd      = dec_i.rd;
	assign retire_o.wdata   = wdata;
	assign retire_o.we      = we && (exc == EXC_NONE);  // exception suppresses write
	assign retire_o.exc     = exc;

	assign illegal_o = (dec_i.encoding == ENC_ILLEGAL);

endmodule

`default_nettype wire

// File: hdl/fetch_sequencer.sv
/* one instruction in flight, no ack timeout; a slow slave stalls the core forever
   an illegal opcode halts until reset and produces no retire record */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module fetch_sequencer import rv_core_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   arst_n_i,
	output wb_req_t                     wb_req_o,
	input  wire logic                   wb_ack_i,
	input  wire logic [`RV_XLEN-1:0]    wb_dat_i,
	output logic [31:0]                 instr_o,    // held word to decoder
	output logic [`RV_XLEN-1:0]         pc_o,
	input  retire_t                     retire_i,
	input  wire logic                   illegal_i,
	output logic                        rf_we_o,
	output logic [4:0]                  rf_waddr_o,
	output logic [`RV_XLEN-1:0]         rf_wdata_o,
	output logic                        retire_valid_o,
	output retire_t                     retire_o,
	output logic                        halted_o
);

	seq_state_e             state_q;
	logic [`RV_XLEN-1:0]    pc_q;
	logic [31:0]            ir_q;
	logic                   cyc_q;
	logic                   stb_q;
	logic                   ack_seen;

	assign ack_seen = (state_q == ST_FETCH) && cyc_q && wb_ack_i;  // transfer ends here

	// control state
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_FETCH;
			pc_q    <= `RV_RESET_PC;
			cyc_q   <= 1'b0;
			stb_q   <= 1'b0;
		end else begin
			case (state_q)
				ST_FETCH: begin
					if (!cyc_q) begin  // only right after reset
						cyc_q <= 1'b1;
						stb_q <= 1'b1;
					end else if (wb_ack_i) begin
						cyc_q   <= 1'b0;
						stb_q   <= 1'b0;
						state_q <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					if (illegal_i) begin
						state_q <= ST_HALT;
					end else begin
						pc_q    <= retire_i.next_pc;
						cyc_q   <= 1'b1;  // next request right away
						stb_q   <= 1'b1;
						state_q <= ST_FETCH;
					end
				end
				default: ;  // ST_HALT, bus stays idle
			endcase
		end
	end

	// instruction register, sampled in the ack cycle
	always_ff @(posedge clk_i) begin
		if (ack_seen) ir_q <= wb_dat_i;
	end

	// outputs
	// ------------------------------
	assign wb_req_o.cyc = cyc_q;
	assign wb_req_o.stb = stb_q;
	assign wb_req_o.adr = pc_q;  // pc only moves with cyc low or rising
	assign instr_o      = ir_q;
	assign pc_o         = pc_q;

	assign retire_valid_o = (state_q == ST_EXEC) && !illegal_i;
	assign halted_o       = (state_q == ST_HALT) || ((state_q == ST_EXEC) && illegal_i);

	assign rf_we_o    = retire_valid_o && retire_i.we;
	assign rf_waddr_o = retire_i.rd;
	assign rf_wdata_o = retire_i.wdata;
	assign retire_o   = retire_i;

	// request held with a stable address until the ack cycle
	a_req_held_until_ack: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(wb_req_o.cyc && !wb_ack_i) |=>
			(wb_req_o.cyc && wb_req_o.stb && $stable(wb_req_o.adr))
	) else $error("wishbone request dropped or address moved before ack");

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
/* purely combinational; only JAL, JALR, branches, ADDI and LUI are known
   anything else, OP-IMM with func3 other than 0 included, is ENC_ILLEGAL */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module instr_decoder import rv_core_pkg::*; (
	input  wire logic [31:0]    instr_i,  // fetched word
	output decoded_t            dec_o
);

	logic [6:0]         opcode;
	logic [31:0]        imm_i_fmt;
	logic [31:0]        imm_j_fmt;
	logic [31:0]        imm_b_fmt;
	logic [31:0]        imm_u_fmt;

	assign opcode = instr_i[6:0];

	// immediate formats
	// ------------------------------
	assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_j_fmt = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
	assign imm_b_fmt = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_fmt = {instr_i[31:12], 12'b0};  // upper 20 bits, no extension needed

	// register fields always extracted, unused ones are ignored downstream
	assign dec_o.func3 = instr_i[14:12];
	assign dec_o.rd    = instr_i[11:7];
	assign dec_o.rs1   = instr_i[19:15];
	assign dec_o.rs2   = instr_i[24:20];

	// class and immediate select
	// ------------------------------
	always_comb begin
		dec_o.encoding = ENC_ILLEGAL;  // default, halts the core
		dec_o.imm      = '0;
		case (opcode)
			`RV_OPC_JAL: begin
				dec_o.encoding = ENC_JAL;
				dec_o.imm      = imm_j_fmt;
			end
			`RV_OPC_JALR: begin
				if (instr_i[14:12] == 3'b000) dec_o.encoding = ENC_JALR;
				dec_o.imm = imm_i_fmt;
			end
			`RV_OPC_BRANCH: begin
				dec_o.encoding = ENC_BRANCH;  // func3 checked in target generator
				dec_o.imm      = imm_b_fmt;
			end
			`RV_OPC_OPIMM: begin
				if (instr_i[14:12] == 3'b000) dec_o.encoding = ENC_ADDI;
				dec_o.imm = imm_i_fmt;
			end
			`RV_OPC_LUI: begin
				dec_o.encoding = ENC_LUI;
				dec_o.imm      = imm_u_fmt;
			end
			default: ;  // stays illegal
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
/* two combinational read ports, one synchronous write port
   x0 reads zero, writes to it are dropped */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module register_file (
	input  wire logic                   clk_i,
	input  wire logic                   arst_n_i,
	input  wire logic [4:0]             raddr1_i,
	input  wire logic [4:0]             raddr2_i,
	output logic [`RV_XLEN-1:0]         rdata1_o,
	output logic [`RV_XLEN-1:0]         rdata2_o,
	input  wire logic                   we_i,
	input  wire logic [4:0]             waddr_i,
	input  wire logic [`RV_XLEN-1:0]    wdata_i
);

	logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `RV_NREGS; i++) regs_q[i] <= '0;
		end else if (we_i && waddr_i != 5'd0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs_q[raddr1_i];  // no bypass, write lands before next read
	assign rdata2_o = regs_q[raddr2_i];

	a_x0_zero: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(raddr1_i == 5'd0) |-> (rdata1_o == '0)
	) else $error("x0 read back non-zero");

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
/* shared enums and records of the control-flow core
   record layouts are fixed, the testbench unpacks them field by field */
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

	// decoded instruction class
	typedef enum logic [2:0] {
		ENC_JAL,
		ENC_JALR,
		ENC_BRANCH,
		ENC_ADDI,
		ENC_LUI,
		ENC_ILLEGAL
	} encoding_e;

	// branch func3 codes, 3'b010 and 3'b011 are not defined
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_func3_e;

	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_BAD_FUNC3,
		EXC_MISALIGNED
	} exc_e;

	typedef enum logic [1:0] {
		ST_FETCH,  // wishbone read in progress
		ST_EXEC,   // one cycle, commit and retire
		ST_HALT    // sticky until reset
	} seq_state_e;

	// decoder output
	typedef struct packed {
		encoding_e              encoding;
		logic [2:0]             func3;
		logic [4:0]             rd;
		logic [4:0]             rs1;
		logic [4:0]             rs2;
		logic [`RV_XLEN-1:0]    imm;  // sign extended, format by class
	} decoded_t;

	// one retired instruction
	typedef struct packed {
		logic [`RV_XLEN-1:0]    pc;
		logic [`RV_XLEN-1:0]    next_pc;
		logic [4:0]             rd;
		logic [`RV_XLEN-1:0]    wdata;
		logic                   we;
		exc_e                   exc;
	} retire_t;

	// wishbone classic master request, read only
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic [`RV_XLEN-1:0]    adr;
	} wb_req_t;

endpackage

`default_nettype wire

// File: hdl/target_address_generator.sv
/* combinational target and link computation; the clock only samples the assertion
   target bit 0 is never set, immediates are even and JALR clears it */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module target_address_generator import rv_core_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   arst_n_i,
	input  decoded_t                    dec_i,
	input  wire logic [`RV_XLEN-1:0]    pc_i,              // address of the current instruction
	input  wire logic [`RV_XLEN-1:0]    src1_i,
	input  wire logic [`RV_XLEN-1:0]    src2_i,
	output logic                        flag_jump_o,       // jump or valid branch
	output logic [`RV_XLEN-1:0]         addr_target_o,     // next pc when flagged
	output logic [`RV_XLEN-1:0]         addr_writeback_o,  // link value for jumps
	output exc_e                        exc_o
);

	logic [`RV_XLEN-1:0]    pc_plus4;
	logic [`RV_XLEN-1:0]    pc_rel;     // pc + imm
	logic                   taken;
	logic                   bad_func3;

	assign pc_plus4 = pc_i + 32'd4;
	assign pc_rel   = pc_i + dec_i.imm;

	// target select
	// ------------------------------
	always_comb begin
		flag_jump_o      = 1'b0;
		addr_target_o    = '0;
		addr_writeback_o = '0;
		bad_func3        = 1'b0;
		taken            = 1'b0;
		case (dec_i.encoding)
			ENC_JAL: begin
				flag_jump_o      = 1'b1;
				addr_writeback_o = pc_plus4;  // return address
				addr_target_o    = pc_rel;
			end
			ENC_JALR: begin
				flag_jump_o      = 1'b1;
				addr_writeback_o = pc_plus4;
				addr_target_o    = (src1_i + dec_i.imm) & ~32'h1;  // register relative, lsb cleared
			end
			ENC_BRANCH: begin
				flag_jump_o = 1'b1;
				case (branch_func3_e'(dec_i.func3))
					BR_BEQ:  taken = (src1_i == src2_i);
					BR_BNE:  taken = (src1_i != src2_i);
					BR_BLT:  taken = ($signed(src1_i) <  $signed(src2_i));
					BR_BGE:  taken = ($signed(src1_i) >= $signed(src2_i));
					BR_BLTU: taken = (src1_i <  src2_i);
					BR_BGEU: taken = (src1_i >= src2_i);
					default: begin
						flag_jump_o = 1'b0;  // unsupported variant
						bad_func3   = 1'b1;
					end
				endcase
				addr_target_o = taken ? pc_rel : pc_plus4;  // fall through when not taken
			end
			default: ;  // ADDI, LUI, illegal: no control flow
		endcase
	end

	// exceptions
	// ------------------------------
	// word misalignment only matters for a target that is actually followed
	assign exc_o = bad_func3                         ? EXC_BAD_FUNC3  :
	               (flag_jump_o && addr_target_o[1]) ? EXC_MISALIGNED : EXC_NONE;

	// even offsets and the JALR clear keep bit 0 of a followed target low
	a_target_lsb_clear: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		flag_jump_o |-> !addr_target_o[0]
	) else $error("flagged target with bit 0 set");

endmodule

`default_nettype wire

// File: include/rv_core_macros.svh
/* core-wide constants, RV32I only; the reset PC must be word aligned
   opcode values cover only the classes that the decoder knows */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// widths and sizes
// ------------------------------
`define RV_XLEN      32             // data and address width
`define RV_NREGS     32             // architectural registers, x0 included
`define RV_RESET_PC  32'h0000_0000  // first fetch address

// major opcode field, instr[6:0]
// ------------------------------
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_OPIMM   7'b0010011  // only func3 0 (ADDI) is decoded
`define RV_OPC_LUI     7'b0110111

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the branch core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_core -f all.f

sim_out=$(./obj_dir/Vtb_branch_core 2>&1 || true)
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi

// File: testbench/branch_stimulus.mem
// word 0 is the program word count, then the program words from address 0
// then one retire record per line: pc next_pc rd wdata we exc, last the record count
00000021
00500093 FFD00113 800001B7 00700013 00500213 00208463 00408463 00000000
00601463 00209463 00000000 0020C463 00114463 00000000 00115463 0030D463
00000000 00116463 0020E463 00000000 0020F463 00117463 00000000 008003EF
00000000 06C00493 00548467 00000000 00248567 0010A463 01038593 00150613
00000000
00000000 00000004 01 00000005 1 0  // addi x1, 5
00000004 00000008 02 FFFFFFFD 1 0  // addi x2, -3
00000008 0000000C 03 80000000 1 0  // lui x3
0000000C 00000010 00 00000007 1 0  // addi x0, discarded
00000010 00000014 04 00000005 1 0  // addi x4, 5
00000014 00000018 00 00000000 0 0  // beq not taken
00000018 00000020 00 00000000 0 0  // beq taken
00000020 00000024 00 00000000 0 0  // bne x0 x6 not taken
00000024 0000002C 00 00000000 0 0  // bne taken
0000002C 00000030 00 00000000 0 0  // blt not taken
00000030 00000038 00 00000000 0 0  // blt taken
00000038 0000003C 00 00000000 0 0  // bge not taken
0000003C 00000044 00 00000000 0 0  // bge taken
00000044 00000048 00 00000000 0 0  // bltu not taken
00000048 00000050 00 00000000 0 0  // bltu taken
00000050 00000054 00 00000000 0 0  // bgeu not taken
00000054 0000005C 00 00000000 0 0  // bgeu taken
0000005C 00000064 07 00000060 1 0  // jal x7
00000064 00000068 09 0000006C 1 0  // addi x9
00000068 00000070 08 0000006C 1 0  // jalr x8, odd sum
00000070 00000074 00 00000000 0 2  // jalr misaligned
00000074 00000078 00 00000000 0 1  // branch func3 2
00000078 0000007C 0B 00000070 1 0  // addi x11 from jal link
0000007C 00000080 0C 00000001 1 0  // addi x12, x10 unwritten
00000018

// File: testbench/tb_branch_core.sv
/* self-checking testbench, expected retire records come from the stimulus file
   the memory model answers after 0 to 3 wait cycles, words past the program are illegal */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_branch_core import rv_core_pkg::*; ();

	localparam int STIM_WORDS = 256;  // program, records and total

	logic                   clk;
	logic                   arst_n;
	wb_req_t                wb_req;
	logic                   wb_ack = 1'b0;
	logic [`RV_XLEN-1:0]    wb_dat = '0;
	logic                   retire_valid;
	retire_t                retire;
	logic                   halted;

	logic [31:0]            stim [STIM_WORDS];
	int                     n_prog;      // program words
	int                     n_records;
	int                     exp_total;   // retire count from the file
	int                     last;
	int                     idx;
	int                     base;
	int                     cycle_limit;
	int                     cycle_cnt = 0;
	int                     rec_idx = 0;
	logic [15:0]            lfsr_state = 16'd15;  // seed
	logic [1:0]             delay;
	logic [1:0]             wait_left = '0;
	logic                   serving = 1'b0;
	logic [`RV_XLEN-1:0]    last_ack_adr = '0;
	logic                   halt_seen = 1'b0;

	branch_core_top u_branch_core_top (
		.clk_i          (clk),
		.arst_n_i       (arst_n),
		.wb_req_o       (wb_req),
		.wb_ack_i       (wb_ack),
		.wb_dat_i       (wb_dat),
		.retire_valid_o (retire_valid),
		.retire_o       (retire),
		.halted_o       (halted)
	);

	always #2 clk = ~clk;  // 4 ns period

	// helpers
	// ------------------------------
	function automatic logic [31:0] unused_word(input int i);
		unused_word = 32'hA5A5_0000 ^ 32'(i);  // marks words the file did not load
	endfunction

	// galois lfsr, 16 bit, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] adr);
		int widx;
		widx = int'(adr[31:2]);
		if (widx < n_prog) fetch_word = stim[1 + widx];
		else fetch_word = adr ^ 32'hA5A5_A500;  // low bits 00, never a known opcode
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp_val,
	                          input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			$display("error %s: expected %h, actual %h", name, exp_val, act_val);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic ack_request();
		wb_ack       <= 1'b1;
		wb_dat       <= fetch_word(wb_req.adr);
		last_ack_adr <= wb_req.adr;
	endtask

	// wishbone classic slave
	// ------------------------------
	always @(posedge clk) begin
		if (!arst_n) begin
			wb_ack  <= 1'b0;
			serving <= 1'b0;
		end else if (wb_ack) begin
			wb_ack  <= 1'b0;  // single ack cycle, master drops cyc here
			serving <= 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!serving) begin
				lfsr_state = lfsr_step(lfsr_state);  // one step per delay bit
				delay[0]   = lfsr_state[0];
				lfsr_state = lfsr_step(lfsr_state);
				delay[1]   = lfsr_state[0];
				serving   <= 1'b1;
				if (delay == 2'd0) ack_request();
				else wait_left <= delay;
			end else if (wait_left == 2'd1) begin
				ack_request();
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	// retire checker
	// ------------------------------
	always @(posedge clk) begin
		if (arst_n && retire_valid) begin
			assert (rec_idx < n_records)
			else stop_with_error("core retired more instructions than expected");
			base = n_prog + 1 + 6 * rec_idx;
			check_word($sformatf("retire[%0d] fetch adr", rec_idx), stim[base], last_ack_adr);
			check_word($sformatf("retire[%0d] pc", rec_idx), stim[base], retire.pc);
			check_word($sformatf("retire[%0d] next_pc", rec_idx), stim[base + 1], retire.next_pc);
			check_word($sformatf("retire[%0d] we", rec_idx), stim[base + 4], {31'b0, retire.we});
			check_word($sformatf("retire[%0d] exc", rec_idx), stim[base + 5], {30'b0, retire.exc});
			if (stim[base + 4][0]) begin  // rd and data only count when written
				check_word($sformatf("retire[%0d] rd", rec_idx), stim[base + 2], {27'b0, retire.rd});
				check_word($sformatf("retire[%0d] wdata", rec_idx), stim[base + 3], retire.wdata);
			end
			rec_idx <= rec_idx + 1;
		end
	end

	// halt is sticky and the bus stays idle
	always @(posedge clk) begin
		if (arst_n && halt_seen) begin
			assert (halted) else stop_with_error("halted_o dropped before reset");
			assert (!wb_req.cyc && !wb_req.stb)
			else stop_with_error("wishbone request issued after halt");
		end
		if (arst_n && halted) halt_seen <= 1'b1;
	end

	// main sequence
	// ------------------------------
	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
		for (idx = 0; idx < STIM_WORDS; idx++) stim[idx] = unused_word(idx);
		$readmemh("testbench/branch_stimulus.mem", stim);
		last = STIM_WORDS - 1;
		while (last > 0 && stim[last] == unused_word(last)) last--;
		n_prog    = int'(stim[0]);
		exp_total = int'(stim[last]);  // total count closes the file
		n_records = (last - n_prog - 1) / 6;
		assert (n_prog > 0 && (last - n_prog - 1) % 6 == 0)
		else stop_with_error("stimulus file does not hold whole retire records");
		cycle_limit = (n_records + 1) * 8;  // 4 wait + exec per instruction, with margin

		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		while (!halted && cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end

		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end else begin
			repeat (8) @(posedge clk);  // watch the halted core for a while
			if (rec_idx == exp_total && rec_idx == n_records) begin
				$display("TESTBENCH PASSED");
				$finish;
			end else begin
				$display("error retire count: expected %0d, actual %0d", exp_total, rec_idx);
				$display("TESTBENCH FAILED");
				$fatal(1, "retire count mismatch");
			end
		end
	end

endmodule

`default_nettype wire
